// ==== source/qspi_pkg.sv ====
`default_nettype none

package qspi_pkg;

   ////////////////////
   // Widths with a meaning

   typedef logic [23:0] addr_t;           // Register bus byte address
   typedef logic [31:0] word_t;           // Register bus data word
   typedef logic [7:0]  opcode_t;         // SPI command byte
   typedef logic [5:0]  bit_cnt_t;        // Clocks left in a phase, minus one

   localparam int CMD_CLKS  = 8;          // Opcode always single lane
   localparam int WORD_BITS = 32;
   localparam int ADDR_BITS = 24;

   ////////////////////
   // Flash opcodes

   localparam opcode_t OP_READ           = 8'h03; // Read Data
   localparam opcode_t OP_FAST_READ      = 8'h0B; // Fast Read, 8 dummy
   localparam opcode_t OP_QUAD_OUT_READ  = 8'h6B; // Quad data out, 8 dummy
   localparam opcode_t OP_QUAD_IO_READ   = 8'hEB; // Quad addr and data, 6 dummy
   localparam opcode_t OP_PAGE_PROG      = 8'h02; // Page Program
   localparam opcode_t OP_QUAD_PAGE_PROG = 8'h32; // Quad data in

   typedef enum logic {
      LANE_SINGLE = 1'b0,                 // sdin[0] / sdout[0]
      LANE_QUAD   = 1'b1                  // All four lanes, [3] is MSB
   } lane_e;

   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_CMD   = 3'd1,
      ST_ADDR  = 3'd2,
      ST_DUMMY = 3'd3,
      ST_WRITE = 3'd4,
      ST_READ  = 3'd5,
      ST_EXIT  = 3'd6                     // Park until ssn released
   } spi_state_e;

   ////////////////////
   // Block to block bundles

   typedef struct packed {
      logic       sck_rise;               // One cycle pulse
      logic       sck_fall;               // One cycle pulse
      logic       ssn_active;             // Filtered select level
      logic [3:0] din;                    // sdin seen with sclk samples
   } spi_evt_t;

   typedef struct packed {
      logic  addr_shift;
      logic  wdata_shift;
      logic  rdata_shift;                 // Falling edge, one cycle late
      logic  addr_inc;                    // Step address by 4
      lane_e lane;                        // Width of the active shift
   } shift_ctl_t;

   typedef struct packed {
      logic  rd;                          // Held until ack
      logic  wr;                          // Held until ack
      addr_t addr;
      word_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic  ack;                         // Single cycle
      word_t rdata;                       // Valid with ack
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== source/qspi_sync.sv ====
`default_nettype none

module qspi_sync #(
   parameter int SYNC_STAGES = 2
) (
   input  wire                 sys_clk,
   input  wire                 rst_n,
   input  wire                 sclk,
   input  wire                 ssn,
   input  wire  [3:0]          sdin,
   output qspi_pkg::spi_evt_t  evt
);

   localparam logic [5:0] PIN_IDLE = 6'b11_0000;   // sclk, ssn high, sdin low

   logic [SYNC_STAGES-1:0][5:0] sync_q;            // {sclk, ssn, sdin} per stage
   logic [5:0]                  pins_s;            // Newest synced sample
   logic                        sck_d1;            // Edge history
   logic                        sck_d2;
   logic                        ssn_d1;            // For select hysteresis
   logic                        rise;
   logic                        fall;
   logic                        sck_edge;          // Either sclk edge flagged

   assign pins_s = sync_q[SYNC_STAGES-1];

   // Two equal samples after a different one
   assign rise = pins_s[5] & sck_d1 & ~sck_d2;
   assign fall = ~pins_s[5] & ~sck_d1 & sck_d2;

   assign sck_edge = evt.sck_rise | evt.sck_fall;

   ////////////////////
   // Sync chain and history

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= {SYNC_STAGES{PIN_IDLE}};
         sck_d1 <= 1'b1;                           // sclk taken as idle high
         sck_d2 <= 1'b1;
         ssn_d1 <= 1'b1;
      end else begin
         sync_q[0] <= {sclk, ssn, sdin};
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         sck_d1 <= pins_s[5];
         sck_d2 <= sck_d1;
         ssn_d1 <= pins_s[4];
      end
   end

   ////////////////////
   // Registered events

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         evt <= '0;                                // Deselected, no edges
      end else begin
         evt.sck_rise <= rise;
         evt.sck_fall <= fall;
         evt.din      <= pins_s[3:0];              // Same stage as sclk
         if (!pins_s[4] && !ssn_d1) begin
            evt.ssn_active <= 1'b1;                // Low twice, select
         end else if (pins_s[4] && ssn_d1) begin
            evt.ssn_active <= 1'b0;                // High twice, release
         end
      end
   end

   // sclk half period of at least 8 sys_clk cycles
   a_half_period: assert property (@(posedge sys_clk) disable iff (!rst_n)
      sck_edge |-> !($past(sck_edge, 1) || $past(sck_edge, 2) || $past(sck_edge, 3) ||
                     $past(sck_edge, 4) || $past(sck_edge, 5) || $past(sck_edge, 6) ||
                     $past(sck_edge, 7)));

endmodule

`default_nettype wire

// ==== source/qspi_cmd_fsm.sv ====
`default_nettype none

module qspi_cmd_fsm (
   input  wire                   sys_clk,
   input  wire                   rst_n,
   input  wire qspi_pkg::spi_evt_t evt,
   input  wire                   ack,
   output qspi_pkg::shift_ctl_t  ctl,
   output logic                  rd,
   output logic                  wr,
   output logic                  sdout_oen
);

   localparam qspi_pkg::bit_cnt_t FAST_DUMMY = 6'd8;  // 0B, 6B
   localparam qspi_pkg::bit_cnt_t QIO_DUMMY  = 6'd6;  // EB

   qspi_pkg::spi_state_e state;
   qspi_pkg::bit_cnt_t   bit_cnt;        // Reaches 0 on last clock of phase
   qspi_pkg::opcode_t    op_q;           // Opcode shift register
   qspi_pkg::opcode_t    op_next;        // Including the bit now seen
   qspi_pkg::lane_e      addr_lane;
   qspi_pkg::lane_e      data_lane;
   qspi_pkg::bit_cnt_t   dummy_clks;     // Zero for plain read and writes
   logic                 is_read;
   logic                 fall_d;         // sck_fall one cycle late
   logic                 addr_inc;
   logic                 data_start;     // Last addr or dummy clock

   logic                 dec_known;
   qspi_pkg::lane_e      dec_alane;
   qspi_pkg::lane_e      dec_dlane;
   qspi_pkg::bit_cnt_t   dec_dummy;
   logic                 dec_read;

   // Clock count of a phase, minus one
   function automatic qspi_pkg::bit_cnt_t phase_clks(input qspi_pkg::lane_e lane,
                                                     input int bits);
      if (lane == qspi_pkg::LANE_QUAD) begin
         return qspi_pkg::bit_cnt_t'(bits / 4 - 1);
      end
      return qspi_pkg::bit_cnt_t'(bits - 1);
   endfunction

   assign op_next = {op_q[6:0], evt.din[0]};     // MSB first on sdin[0]

   ////////////////////
   // Opcode lookup

   always_comb begin
      dec_known = 1'b1;
      dec_alane = qspi_pkg::LANE_SINGLE;
      dec_dlane = qspi_pkg::LANE_SINGLE;
      dec_dummy = '0;
      dec_read  = 1'b1;
      case (op_next)
         qspi_pkg::OP_READ:          dec_dummy = '0;    // Straight to data
         qspi_pkg::OP_FAST_READ:     dec_dummy = FAST_DUMMY;
         qspi_pkg::OP_QUAD_OUT_READ: begin
            dec_dummy = FAST_DUMMY;
            dec_dlane = qspi_pkg::LANE_QUAD;
         end
         qspi_pkg::OP_QUAD_IO_READ: begin
            dec_dummy = QIO_DUMMY;
            dec_alane = qspi_pkg::LANE_QUAD;            // 6 address clocks
            dec_dlane = qspi_pkg::LANE_QUAD;
         end
         qspi_pkg::OP_PAGE_PROG:     dec_read = 1'b0;
         qspi_pkg::OP_QUAD_PAGE_PROG: begin
            dec_read  = 1'b0;
            dec_dlane = qspi_pkg::LANE_QUAD;
         end
         default:                    dec_known = 1'b0;  // Status, ID etc.
      endcase
   end

   assign data_start = evt.sck_rise && (bit_cnt == '0) &&
                       ((state == qspi_pkg::ST_ADDR && dummy_clks == '0) ||
                        state == qspi_pkg::ST_DUMMY);

   ////////////////////
   // Phase FSM

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= qspi_pkg::ST_IDLE;
         bit_cnt    <= '0;
         op_q       <= '0;
         addr_lane  <= qspi_pkg::LANE_SINGLE;
         data_lane  <= qspi_pkg::LANE_SINGLE;
         dummy_clks <= '0;
         is_read    <= 1'b0;
         rd         <= 1'b0;
         wr         <= 1'b0;
         sdout_oen  <= 1'b1;
      end else if (!evt.ssn_active) begin         // Abort on release
         state     <= qspi_pkg::ST_IDLE;
         rd        <= 1'b0;
         wr        <= 1'b0;
         sdout_oen <= 1'b1;
      end else begin
         if (ack) begin                            // Request done
            rd <= 1'b0;
            wr <= 1'b0;
         end
         if (data_start) begin
            state     <= is_read ? qspi_pkg::ST_READ : qspi_pkg::ST_WRITE;
            bit_cnt   <= phase_clks(data_lane, qspi_pkg::WORD_BITS);
            rd        <= is_read;                  // First word fetched early
            sdout_oen <= ~is_read;
         end else begin
            case (state)
               qspi_pkg::ST_IDLE: begin
                  state   <= qspi_pkg::ST_CMD;
                  bit_cnt <= qspi_pkg::bit_cnt_t'(qspi_pkg::CMD_CLKS - 1);
               end
               qspi_pkg::ST_CMD: if (evt.sck_rise) begin
                  op_q <= op_next;
                  if (bit_cnt == '0) begin
                     addr_lane  <= dec_alane;
                     data_lane  <= dec_dlane;
                     dummy_clks <= dec_dummy;
                     is_read    <= dec_read;
                     bit_cnt    <= phase_clks(dec_alane, qspi_pkg::ADDR_BITS);
                     state      <= dec_known ? qspi_pkg::ST_ADDR : qspi_pkg::ST_EXIT;
                  end else begin
                     bit_cnt <= bit_cnt - 1'b1;
                  end
               end
               qspi_pkg::ST_ADDR: if (evt.sck_rise) begin
                  if (bit_cnt == '0) begin          // Dummy clocks follow
                     state   <= qspi_pkg::ST_DUMMY;
                     bit_cnt <= dummy_clks - 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt - 1'b1;
                  end
               end
               qspi_pkg::ST_DUMMY: if (evt.sck_rise) begin
                  bit_cnt <= bit_cnt - 1'b1;
               end
               qspi_pkg::ST_READ, qspi_pkg::ST_WRITE: if (evt.sck_rise) begin
                  if (bit_cnt == '0) begin          // Word boundary
                     rd      <= (state == qspi_pkg::ST_READ);
                     wr      <= (state == qspi_pkg::ST_WRITE);
                     bit_cnt <= phase_clks(data_lane, qspi_pkg::WORD_BITS);
                  end else begin
                     bit_cnt <= bit_cnt - 1'b1;
                  end
               end
               qspi_pkg::ST_EXIT: state <= qspi_pkg::ST_EXIT;   // Wait for ssn
               default:           state <= qspi_pkg::ST_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         fall_d   <= 1'b0;
         addr_inc <= 1'b0;
      end else begin
         fall_d   <= evt.sck_fall;
         addr_inc <= ack & (rd | wr);              // Step after each word
      end
   end

   always_comb begin
      ctl.addr_shift  = (state == qspi_pkg::ST_ADDR) && evt.sck_rise;
      ctl.wdata_shift = (state == qspi_pkg::ST_WRITE) && evt.sck_rise;
      ctl.rdata_shift = (state == qspi_pkg::ST_READ) && fall_d;
      ctl.addr_inc    = addr_inc;
      ctl.lane        = (state == qspi_pkg::ST_ADDR) ? addr_lane : data_lane;
   end

   a_rd_wr_excl: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(rd && wr));

   // Request stays up until the bus answers, unless ssn drops
   a_req_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
      (rd || wr) && !ack && evt.ssn_active |=> $stable({rd, wr}));

endmodule

`default_nettype wire

// ==== source/qspi_shift.sv ====
`default_nettype none

module qspi_shift (
   input  wire                     sys_clk,
   input  wire                     rst_n,
   input  wire qspi_pkg::spi_evt_t   evt,
   input  wire qspi_pkg::shift_ctl_t ctl,
   input  wire qspi_pkg::bus_rsp_t   rsp,
   output qspi_pkg::addr_t         addr,
   output qspi_pkg::word_t         wdata,
   output logic [3:0]              sdout
);

   qspi_pkg::word_t rdata_q;            // Output shifter
   logic            quad;

   assign quad = (ctl.lane == qspi_pkg::LANE_QUAD);

   ////////////////////
   // Address and write data

   always_ff @(posedge sys_clk) begin
      if (ctl.addr_shift) begin
         if (quad) begin
            addr <= {addr[19:0], evt.din};         // sdin[3] is MSB
         end else begin
            addr <= {addr[22:0], evt.din[0]};
         end
      end else if (ctl.addr_inc) begin
         addr <= addr + qspi_pkg::addr_t'(4);      // Next word
      end
   end

   always_ff @(posedge sys_clk) begin
      if (ctl.wdata_shift) begin
         if (quad) begin
            wdata <= {wdata[27:0], evt.din};
         end else begin
            wdata <= {wdata[30:0], evt.din[0]};
         end
      end
   end

   ////////////////////
   // Read data out

   always_ff @(posedge sys_clk) begin
      if (rsp.ack) begin
         rdata_q <= rsp.rdata;                     // Fresh word
      end else if (ctl.rdata_shift) begin
         if (quad) begin
            rdata_q <= {rdata_q[27:0], 4'b0000};
         end else begin
            rdata_q <= {rdata_q[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sdout <= '0;
      end else if (ctl.rdata_shift && !rsp.ack) begin
         if (quad) begin
            sdout <= rdata_q[31:28];               // Nibble per falling edge
         end else begin
            sdout <= {3'b111, rdata_q[31]};        // Spare lanes parked high
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/qspi_slave.sv ====
`default_nettype none

module qspi_slave #(
   parameter int SYNC_STAGES = 2
) (
   input  wire                   sys_clk,
   input  wire                   rst_n,
   input  wire                   sclk,
   input  wire                   ssn,
   input  wire  [3:0]            sdin,
   output logic [3:0]            sdout,
   output logic                  sdout_oen,
   output qspi_pkg::bus_req_t    bus_req,
   input  wire qspi_pkg::bus_rsp_t bus_rsp
);

   qspi_pkg::spi_evt_t   evt;             // Synced pins and sclk edges
   qspi_pkg::shift_ctl_t ctl;             // Shift enables from FSM
   logic                 rd;
   logic                 wr;
   qspi_pkg::addr_t      addr;
   qspi_pkg::word_t      wdata;

   qspi_sync #(
      .SYNC_STAGES (SYNC_STAGES)
   ) sync_i (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .sclk    (sclk),
      .ssn     (ssn),
      .sdin    (sdin),
      .evt     (evt)
   );

   qspi_cmd_fsm fsm_i (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .evt       (evt),
      .ack       (bus_rsp.ack),
      .ctl       (ctl),
      .rd        (rd),
      .wr        (wr),
      .sdout_oen (sdout_oen)
   );

   qspi_shift shift_i (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .evt     (evt),
      .ctl     (ctl),
      .rsp     (bus_rsp),
      .addr    (addr),
      .wdata   (wdata),
      .sdout   (sdout)
   );

   assign bus_req = '{rd: rd, wr: wr, addr: addr, wdata: wdata};   // Register bus out

endmodule

`default_nettype wire

// ==== verification/qspi_slave_tb.sv ====
`default_nettype none

module qspi_slave_tb;

   localparam int          HALF      = 16;          // sys_clk cycles per sclk half period
   localparam int          MEM_WORDS = 64;
   localparam int          ACK_DELAY = 2;           // Cycles from request rise to ack
   localparam logic [31:0] SEED      = 32'hf2fb98f2;
   localparam int          NUM_TXNS  = 9;

   typedef struct packed {
      qspi_pkg::opcode_t op;
      qspi_pkg::addr_t   addr;                      // Start address
      int                words;                     // Data words clocked
      int                abort_bits;                // Release ssn early, 0 for never
   } txn_t;

   typedef struct packed {
      logic            known;
      logic            is_read;
      qspi_pkg::lane_e alane;
      qspi_pkg::lane_e dlane;
      int              dummy;
   } op_info_t;

   ////////////////////
   // Transaction table

   localparam txn_t TXNS [NUM_TXNS] = '{
      '{qspi_pkg::OP_PAGE_PROG,      24'h000010, 2, 0},
      '{qspi_pkg::OP_QUAD_PAGE_PROG, 24'h000040, 2, 0},
      '{qspi_pkg::OP_READ,           24'h000010, 3, 0},    // Reads back first program
      '{qspi_pkg::OP_FAST_READ,      24'h000080, 3, 0},
      '{qspi_pkg::OP_QUAD_OUT_READ,  24'h000040, 2, 0},    // Reads back quad program
      '{qspi_pkg::OP_QUAD_IO_READ,   24'h0000a4, 2, 0},
      '{8'h9f,                       24'h000000, 1, 0},    // ID read, not supported
      '{qspi_pkg::OP_PAGE_PROG,      24'h0000c0, 1, 20},   // Cut after 20 data bits
      '{qspi_pkg::OP_READ,           24'h0000c0, 1, 0}     // Must be untouched
   };

   logic                sys_clk = 1'b0;
   logic                rst_n   = 1'b0;
   logic                sclk    = 1'b0;             // Mode 0 idle low
   logic                ssn     = 1'b1;
   logic [3:0]          sdin    = 4'h0;
   logic [3:0]          sdout;
   logic                sdout_oen;
   qspi_pkg::bus_req_t  bus_req;
   qspi_pkg::bus_rsp_t  bus_rsp = '0;

   qspi_pkg::word_t     mem     [MEM_WORDS];        // Bus side memory
   qspi_pkg::word_t     ref_mem [MEM_WORDS];        // Expected contents
   qspi_pkg::addr_t     req_addr_q  [$];            // One entry per acked request
   qspi_pkg::word_t     req_wdata_q [$];
   logic                req_wr_q    [$];
   int                  req_age  = 0;
   int                  n_checks = 0;
   int                  n_errors = 0;
   logic [31:0]         rng;

   always #2 sys_clk = ~sys_clk;

   qspi_slave #(
      .SYNC_STAGES (2)
   ) dut_i (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .ssn       (ssn),
      .sdin      (sdin),
      .sdout     (sdout),
      .sdout_oen (sdout_oen),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Lanes and dummy clocks per flash opcode
   function automatic op_info_t decode_op(input qspi_pkg::opcode_t op);
      op_info_t info;
      info = '{known: 1'b1, is_read: 1'b1, alane: qspi_pkg::LANE_SINGLE,
               dlane: qspi_pkg::LANE_SINGLE, dummy: 0};
      case (op)
         qspi_pkg::OP_READ:          info.dummy = 0;
         qspi_pkg::OP_FAST_READ:     info.dummy = 8;
         qspi_pkg::OP_QUAD_OUT_READ: begin
            info.dummy = 8;
            info.dlane = qspi_pkg::LANE_QUAD;
         end
         qspi_pkg::OP_QUAD_IO_READ: begin
            info.dummy = 6;
            info.alane = qspi_pkg::LANE_QUAD;
            info.dlane = qspi_pkg::LANE_QUAD;
         end
         qspi_pkg::OP_PAGE_PROG:     info.is_read = 1'b0;
         qspi_pkg::OP_QUAD_PAGE_PROG: begin
            info.is_read = 1'b0;
            info.dlane   = qspi_pkg::LANE_QUAD;
         end
         default: begin
            info.known   = 1'b0;
            info.is_read = 1'b0;
         end
      endcase
      return info;
   endfunction

   // Upper bound on sclk clocks of one row
   function automatic int txn_clks(input txn_t t);
      op_info_t info;
      int       clks;
      info = decode_op(t.op);
      clks = qspi_pkg::CMD_CLKS + t.words * qspi_pkg::WORD_BITS;
      if (info.known) begin
         clks += qspi_pkg::ADDR_BITS + info.dummy;
      end
      return clks;
   endfunction

   ////////////////////
   // Bus memory model

   always @(posedge sys_clk) begin : bus_model
      logic [31:0] x;
      if (!rst_n) begin
         x = SEED;
         for (int i = 0; i < MEM_WORDS; i++) begin
            x = xorshift32(x);
            mem[i] <= x;
         end
         req_age <= 0;
         bus_rsp <= '0;
      end else begin
         req_age <= ((bus_req.rd || bus_req.wr) && !bus_rsp.ack) ? req_age + 1 : 0;
         if ((bus_req.rd || bus_req.wr) && !bus_rsp.ack && req_age == ACK_DELAY - 1) begin
            bus_rsp.ack   <= 1'b1;
            bus_rsp.rdata <= mem[bus_req.addr[7:2]];
            if (bus_req.wr) begin
               mem[bus_req.addr[7:2]] <= bus_req.wdata;
            end
            req_addr_q.push_back(bus_req.addr);      // Log for the checks
            req_wdata_q.push_back(bus_req.wdata);
            req_wr_q.push_back(bus_req.wr);
         end else begin
            bus_rsp.ack <= 1'b0;
         end
      end
   end

   ////////////////////
   // Compare tasks

   task automatic check_addr(input string name, input qspi_pkg::addr_t got,
                             input qspi_pkg::addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input qspi_pkg::word_t got,
                             input qspi_pkg::word_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_oen(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // One mode 0 clock, data set while sclk low
   task automatic spi_clock(input logic [3:0] din, output logic [3:0] dout,
                            output logic oen);
      sdin <= din;
      repeat (HALF) @(posedge sys_clk);
      sclk <= 1'b1;
      dout = sdout;                                   // Master samples on rise
      oen  = sdout_oen;
      repeat (HALF) @(posedge sys_clk);
      sclk <= 1'b0;
   endtask

   task automatic run_txn(input txn_t t);
      op_info_t        info;
      qspi_pkg::word_t sent [$];
      qspi_pkg::word_t wd;
      qspi_pkg::word_t rx;
      qspi_pkg::addr_t exp_addr;
      logic [5:0]      idx;
      logic [3:0]      din;
      logic [3:0]      dout;
      logic            oen;
      int              cpw;
      int              clks;
      int              done;
      int              base;
      int              n_req;
      int              exp_min;
      info = decode_op(t.op);
      cpw  = (info.dlane == qspi_pkg::LANE_QUAD) ? 8 : 32;
      base = req_addr_q.size();
      clks = 0;
      ssn <= 1'b0;
      for (int i = qspi_pkg::CMD_CLKS - 1; i >= 0; i--) begin
         spi_clock({3'b000, t.op[i]}, dout, oen);
         check_oen("sdout_oen", oen, 1'b1);
      end
      if (info.known) begin
         if (info.alane == qspi_pkg::LANE_QUAD) begin
            for (int i = 5; i >= 0; i--) begin
               spi_clock(t.addr[i*4 +: 4], dout, oen);     // sdin[3] carries MSB
               check_oen("sdout_oen", oen, 1'b1);
            end
         end else begin
            for (int i = qspi_pkg::ADDR_BITS - 1; i >= 0; i--) begin
               spi_clock({3'b000, t.addr[i]}, dout, oen);
               check_oen("sdout_oen", oen, 1'b1);
            end
         end
         for (int i = 0; i < info.dummy; i++) begin
            spi_clock(4'h0, dout, oen);
            check_oen("sdout_oen", oen, 1'b1);
         end
      end
      for (int w = 0; w < t.words; w++) begin
         rng  = xorshift32(rng);
         wd   = info.is_read ? 32'h0 : rng;          // Write payload
         rx   = 32'h0;
         done = 0;
         idx  = t.addr[7:2] + 6'(w);
         for (int c = cpw - 1; c >= 0; c--) begin
            if (t.abort_bits != 0 && clks == t.abort_bits) begin
               break;
            end
            din = (info.dlane == qspi_pkg::LANE_QUAD) ? wd[c*4 +: 4] : {3'b000, wd[c]};
            spi_clock(din, dout, oen);
            rx = (info.dlane == qspi_pkg::LANE_QUAD) ? {rx[27:0], dout} : {rx[30:0], dout[0]};
            check_oen("sdout_oen", oen, !(info.known && info.is_read));
            clks++;
            done++;
         end
         if (done == cpw && info.known) begin
            if (info.is_read) begin
               check_word("sdout word", rx, ref_mem[idx]);
            end else begin
               sent.push_back(wd);
               ref_mem[idx] = wd;                     // Complete words only
            end
         end
      end
      repeat (HALF) @(posedge sys_clk);
      ssn <= 1'b1;
      repeat (2 * HALF) @(posedge sys_clk);
      check_oen("sdout_oen", sdout_oen, 1'b1);
      if (bus_req.rd || bus_req.wr) begin
         n_errors++;
         $display("Bus request still high at %0t after ssn release", $time);
      end
      ////////////////////
      // Bus side results
      n_req   = req_addr_q.size() - base;
      exp_min = (info.known && info.is_read) ? t.words : sent.size();
      if (n_req < exp_min) begin
         n_errors++;
         $display("Opcode %h: expected %0d bus requests but saw only %0d",
                  t.op, exp_min, n_req);
      end else if (!(info.known && info.is_read) && n_req > sent.size()) begin
         n_errors++;
         $display("Opcode %h: %0d unexpected bus requests", t.op, n_req - sent.size());
      end
      for (int k = 0; k < n_req; k++) begin
         exp_addr = t.addr + qspi_pkg::addr_t'(4 * k);  // Steps by one word
         check_addr("bus_req.addr", req_addr_q[base + k], exp_addr);
         if (req_wr_q[base + k] == info.is_read) begin
            n_errors++;
            $display("Opcode %h: bus request %0d went the wrong direction", t.op, k);
         end
         if (k < sent.size()) begin
            check_word("bus_req.wdata", req_wdata_q[base + k], sent[k]);
            check_word("memory word", mem[exp_addr[7:2]], sent[k]);
         end
      end
   endtask

   ////////////////////
   // Main sequence

   initial begin : main
      rng = SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         rng = xorshift32(rng);                     // Same fill as bus model
         ref_mem[i] = rng;
      end
      repeat (5) @(posedge sys_clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge sys_clk);
      check_oen("sdout_oen", sdout_oen, 1'b1);      // Reset value
      for (int n = 0; n < NUM_TXNS; n++) begin
         run_txn(TXNS[n]);
      end
      $display("Checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin : watchdog
      int total;
      total = 0;
      for (int i = 0; i < NUM_TXNS; i++) begin
         total += txn_clks(TXNS[i]);
      end
      repeat (total * 64 + 4000) @(posedge sys_clk);
      $display("Timeout: the run did not finish within %0d sys_clk cycles",
               total * 64 + 4000);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== qspi_slave.f ====
source/qspi_pkg.sv
source/qspi_sync.sv
source/qspi_cmd_fsm.sv
source/qspi_shift.sv
source/qspi_slave.sv
verification/qspi_slave_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the qspi_slave testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module qspi_slave_tb \
   -f qspi_slave.f -Mdir obj_dir -o qspi_slave_sim
./obj_dir/qspi_slave_sim > sim.log
cat sim.log

if grep -qF '** PASS **' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
